/* wb_intercon_pkg.sv */
package wb_intercon_pkg;

   // bus widths.
   localparam int aw = 32;
   localparam int dw = 32;
   localparam int sel_w = dw / 8;

   // byte offset inside one slave region.
   localparam int region_bits = 8;

   // upper address bits compared by the decoder.
   localparam int match_w = aw - region_bits;

   typedef logic [dw-1:0] wb_data_t;

   typedef struct packed {
      logic [match_w-1:0]     region;
      logic [region_bits-1:0] offset;
   } wb_adr_split_t;

   // one address word, seen flat or as region plus offset.
   typedef union packed {
      logic [aw-1:0] flat;
      wb_adr_split_t split;
   } wb_adr_u;

endpackage

/* wb_if.sv */
`timescale 1ns/1ps

interface wb_if;

   // request, driven by the master.
   wb_intercon_pkg::wb_adr_u             adr;
   wb_intercon_pkg::wb_data_t            dat_w;
   logic [wb_intercon_pkg::sel_w-1:0]    sel;
   logic                                 we;
   logic                                 cyc;
   logic                                 stb;

   // response, driven by the slave.
   wb_intercon_pkg::wb_data_t            dat_r;
   logic                                 ack;
   logic                                 err;

   modport master (
      output adr, dat_w, sel, we, cyc, stb,
      input  dat_r, ack, err
   );

   modport slave (
      input  adr, dat_w, sel, we, cyc, stb,
      output dat_r, ack, err
   );

endinterface

/* wb_ram.sv */
`timescale 1ns/1ps

module wb_ram #(
   parameter int mem_words = 64
) (
   input  logic   wb_clk_i,
   input  logic   rst_n_i,
   wb_if.slave    bus
);

   localparam int sel_w = wb_intercon_pkg::sel_w;
   localparam int region_bits = wb_intercon_pkg::region_bits;
   localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;
   localparam int lsb = $clog2(sel_w);

   wb_intercon_pkg::wb_data_t mem [mem_words];
   wb_intercon_pkg::wb_data_t rdat_q;
   logic [idx_w-1:0]          word_idx;
   logic                      req;
   logic                      take;
   logic                      ack_q;

   // the array has to fit in one region.
   if (mem_words < 1 || mem_words * sel_w > (1 << region_bits)) begin : g_size_check
      $error("wb_ram: mem_words does not fit in one region");
   end

   // word index from the offset, byte lanes dropped.
   assign word_idx = bus.adr.split.offset[lsb +: idx_w];

   assign req = bus.cyc & bus.stb;

   // accept once, skip the cycle that already shows ack.
   assign take = req & ~ack_q;

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= take;
      end
   end

   // byte lane writes.
   always_ff @(posedge wb_clk_i) begin
      if (take && bus.we) begin
         for (int b = 0; b < sel_w; b++) begin
            if (bus.sel[b]) begin
               mem[word_idx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
            end
         end
      end
   end

   // read data lines up with ack.
   always_ff @(posedge wb_clk_i) begin
      if (take) begin
         rdat_q <= mem[word_idx];
      end
   end

   assign bus.dat_r = rdat_q;
   assign bus.ack   = ack_q & req;
   assign bus.err   = 1'b0;

endmodule

/* wb_mux.sv */
`timescale 1ns/1ps

module wb_mux #(
   parameter int num_slaves = 4
) (
   input  logic   wb_clk_i,
   input  logic   rst_n_i,
   wb_if.slave    m,
   wb_if.master   s [num_slaves]
);

   localparam int match_w = wb_intercon_pkg::match_w;

   logic [num_slaves-1:0]     slave_hit;
   logic [num_slaves-1:0]     ack_vec;
   wb_intercon_pkg::wb_data_t rdt_vec [num_slaves];
   wb_intercon_pkg::wb_data_t rdt_sel;
   logic                      ack_sel;
   logic                      req;
   logic                      miss;
   logic                      err_q;

   // the region field must be able to name every slave.
   if (num_slaves < 1 || num_slaves > (1 << match_w)) begin : g_count_check
      $error("wb_mux: num_slaves out of range for the region field");
   end

   assign req = m.cyc & m.stb;

   for (genvar i = 0; i < num_slaves; i++) begin : g_port
      // region i lives at base i * 256.
      assign slave_hit[i] = (m.adr.split.region == match_w'(i));

      // payload fans out, strobes only to the hit.
      assign s[i].adr   = m.adr;
      assign s[i].dat_w = m.dat_w;
      assign s[i].sel   = m.sel;
      assign s[i].we    = m.we;
      assign s[i].cyc   = m.cyc & slave_hit[i];
      assign s[i].stb   = m.stb & slave_hit[i];

      // collect responses for the return mux.
      assign rdt_vec[i] = s[i].dat_r;
      assign ack_vec[i] = s[i].ack;
   end

   // no region matched.
   assign miss = ~|slave_hit;

   // at most one hit bit is set.
   always_comb begin
      rdt_sel = '0;
      ack_sel = 1'b0;
      for (int i = 0; i < num_slaves; i++) begin
         if (slave_hit[i]) begin
            rdt_sel = rdt_vec[i];
            ack_sel = ack_vec[i];
         end
      end
   end

   // miss flag, one pulse per held request.
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & miss & ~err_q;
      end
   end

   assign m.dat_r = rdt_sel;
   assign m.ack   = ack_sel;
   // only answer a request still on the bus.
   assign m.err   = err_q & req;

endmodule

/* wb_intercon_top.sv */
`timescale 1ns/1ps

module wb_intercon_top #(
   parameter int num_slaves = 4,
   parameter int mem_words = 64
) (
   input  logic                              wb_clk_i,
   input  logic                              rst_n_i,

   // master port.
   input  logic [wb_intercon_pkg::aw-1:0]    wbm_adr_i,
   input  wb_intercon_pkg::wb_data_t         wbm_dat_i,
   input  logic [wb_intercon_pkg::sel_w-1:0] wbm_sel_i,
   input  logic                              wbm_we_i,
   input  logic                              wbm_cyc_i,
   input  logic                              wbm_stb_i,
   output wb_intercon_pkg::wb_data_t         wbm_rdt_o,
   output logic                              wbm_ack_o,
   output logic                              wbm_err_o
);

   wb_if m_bus ();
   wb_if s_bus [num_slaves] ();

   // plain ports onto the master bus.
   assign m_bus.adr.flat = wbm_adr_i;
   assign m_bus.dat_w    = wbm_dat_i;
   assign m_bus.sel      = wbm_sel_i;
   assign m_bus.we       = wbm_we_i;
   assign m_bus.cyc      = wbm_cyc_i;
   assign m_bus.stb      = wbm_stb_i;

   assign wbm_rdt_o = m_bus.dat_r;
   assign wbm_ack_o = m_bus.ack;
   assign wbm_err_o = m_bus.err;

   wb_mux #(
      .num_slaves (num_slaves)
   ) i_mux (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .m        (m_bus),
      .s        (s_bus)
   );

   // one memory per region.
   for (genvar i = 0; i < num_slaves; i++) begin : g_slave
      wb_ram #(
         .mem_words (mem_words)
      ) i_ram (
         .wb_clk_i (wb_clk_i),
         .rst_n_i  (rst_n_i),
         .bus      (s_bus[i])
      );
   end

endmodule

/* wb_intercon_chk.sv */
`timescale 1ns/1ps

module wb_intercon_chk (
   input logic wb_clk_i,
   input logic rst_n_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic err_i
);

   logic req;

   assign req = cyc_i & stb_i;

   a_ack_err_excl: assert property (@(posedge wb_clk_i) !(ack_i && err_i))
      else $error("ack and err high in the same cycle");

   // fixed one cycle latency.
   a_one_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      (req && !ack_i && !err_i) |=> (ack_i || err_i))
      else $error("request not answered one cycle later");

   a_quiet_in_reset: assert property (@(posedge wb_clk_i) !rst_n_i |-> (!ack_i && !err_i))
      else $error("response while in reset");

endmodule

bind wb_intercon_top wb_intercon_chk i_chk (
   .wb_clk_i (wb_clk_i),
   .rst_n_i  (rst_n_i),
   .cyc_i    (wbm_cyc_i),
   .stb_i    (wbm_stb_i),
   .ack_i    (wbm_ack_o),
   .err_i    (wbm_err_o)
);

/* wb_intercon_tb.sv */
`timescale 1ns/1ps

module wb_intercon_tb;

   localparam int num_slaves = 4;
   localparam int mem_words = 64;
   // upper bound on bus accesses over all tests.
   localparam int access_count = 560;

   logic                              clk = 1'b0;
   logic                              rst_n;
   logic [wb_intercon_pkg::aw-1:0]    wbm_adr;
   wb_intercon_pkg::wb_data_t         wbm_dat;
   logic [wb_intercon_pkg::sel_w-1:0] wbm_sel;
   logic                              wbm_we;
   logic                              wbm_cyc;
   logic                              wbm_stb;
   wb_intercon_pkg::wb_data_t         wbm_rdt;
   logic                              wbm_ack;
   logic                              wbm_err;

   wb_intercon_pkg::wb_data_t model_mem [num_slaves][mem_words];
   logic [31:0]               lfsr_q = 32'h562c_0ff1;
   int                        data_errs = 0;
   int                        resp_errs = 0;
   int                        stall_errs = 0;

   wb_intercon_top #(
      .num_slaves (num_slaves),
      .mem_words  (mem_words)
   ) i_dut (
      .wb_clk_i  (clk),
      .rst_n_i   (rst_n),
      .wbm_adr_i (wbm_adr),
      .wbm_dat_i (wbm_dat),
      .wbm_sel_i (wbm_sel),
      .wbm_we_i  (wbm_we),
      .wbm_cyc_i (wbm_cyc),
      .wbm_stb_i (wbm_stb),
      .wbm_rdt_o (wbm_rdt),
      .wbm_ack_o (wbm_ack),
      .wbm_err_o (wbm_err)
   );

   always #5 clk = ~clk;

   initial begin
      #(access_count * 64 * 10);
      $display("watchdog: run did not finish within %0d ns", access_count * 64 * 10);
      $display("Test failed");
      $finish;
   end

   // fibonacci lfsr, taps 32 22 2 1.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic wb_intercon_pkg::wb_data_t fill_word(input logic [31:0] adr);
      return (adr * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
   endfunction

   task automatic check_data(input wb_intercon_pkg::wb_data_t exp,
                             input wb_intercon_pkg::wb_data_t obs, input string msg);
      if (obs !== exp) begin
         $display("Fail at %0t: %s, data expected %h, got %h", $time, msg, exp, obs);
         data_errs++;
      end
   endtask

   task automatic check_resp(input logic exp_ack, input logic exp_err,
                             input logic obs_ack, input logic obs_err, input string msg);
      if (obs_ack !== exp_ack || obs_err !== exp_err) begin
         $display("Fail at %0t: %s, ack/err expected %b/%b, got %b/%b",
                  $time, msg, exp_ack, exp_err, obs_ack, obs_err);
         resp_errs++;
      end
   endtask

   // one classic cycle, called and left 1 ns after a rising edge.
   task automatic wb_access(input logic [31:0] adr, input wb_intercon_pkg::wb_data_t dat,
                            input logic [3:0] sel, input logic we,
                            output wb_intercon_pkg::wb_data_t rdt,
                            output logic ack, output logic err);
      int waited;
      wbm_adr = adr;
      wbm_dat = dat;
      wbm_sel = sel;
      wbm_we  = we;
      wbm_cyc = 1'b1;
      wbm_stb = 1'b1;
      waited = 0;
      ack = 1'b0;
      err = 1'b0;
      rdt = '0;
      while (ack !== 1'b1 && err !== 1'b1 && waited < 4) begin
         @(negedge clk);
         ack = wbm_ack;
         err = wbm_err;
         rdt = wbm_rdt;
         waited++;
      end
      if (ack !== 1'b1 && err !== 1'b1) begin
         $display("bus stalled: no ack or err within 4 cycles at address %h", adr);
         stall_errs++;
      end
      @(posedge clk);
      #1;
      wbm_cyc = 1'b0;
      wbm_stb = 1'b0;
      wbm_we  = 1'b0;
   endtask

   // access plus check against the model memory.
   task automatic checked_access(input logic [31:0] adr, input wb_intercon_pkg::wb_data_t dat,
                                 input logic [3:0] sel, input logic we, input string msg);
      wb_intercon_pkg::wb_data_t rdt;
      wb_intercon_pkg::wb_data_t mask;
      logic                      ack;
      logic                      err;
      logic                      mapped;
      logic [1:0]                r;
      logic [5:0]                w;
      // 256-byte regions from address 0, word index below.
      mapped = (adr[31:8] < 24'(num_slaves));
      r = adr[9:8];
      w = adr[7:2];
      wb_access(adr, dat, sel, we, rdt, ack, err);
      check_resp(mapped, ~mapped, ack, err, msg);
      if (mapped && we) begin
         mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
         model_mem[r][w] = (model_mem[r][w] & ~mask) | (dat & mask);
      end else if (mapped) begin
         check_data(model_mem[r][w], rdt, msg);
      end
   endtask

   task automatic reset_state();
      rst_n = 1'b0;
      @(posedge clk);
      #1;
      // a held miss, then a held read, both inside reset.
      wbm_adr = 32'h0000_0400;
      wbm_we  = 1'b0;
      wbm_cyc = 1'b1;
      wbm_stb = 1'b1;
      repeat (3) begin
         @(negedge clk);
         check_resp(1'b0, 1'b0, wbm_ack, wbm_err, "during reset");
         @(posedge clk);
         #1;
         wbm_adr = 32'h0000_0040;
      end
      rst_n   = 1'b1;
      wbm_cyc = 1'b0;
      wbm_stb = 1'b0;
      repeat (2) begin
         @(negedge clk);
         check_resp(1'b0, 1'b0, wbm_ack, wbm_err, "after reset");
      end
      @(posedge clk);
      #1;
   endtask

   task automatic region_routing();
      logic [31:0] adr;
      for (int r = 0; r < num_slaves; r++) begin
         adr = 32'(r) * 32'h100 + 32'h40;
         checked_access(adr, 32'h5100_0a0a + 32'(r) * 32'h0101_0101, 4'hf, 1'b1,
                        $sformatf("routing write region %0d", r));
      end
      for (int r = 0; r < num_slaves; r++) begin
         adr = 32'(r) * 32'h100 + 32'h40;
         checked_access(adr, '0, 4'hf, 1'b0, $sformatf("routing read region %0d", r));
      end
   endtask

   task automatic byte_lanes();
      logic [31:0] adr;
      adr = 32'h0000_01a4;
      checked_access(adr, 32'h0123_4567, 4'hf, 1'b1, "full word write");
      checked_access(adr, '0, 4'hf, 1'b0, "full word read");
      for (int b = 0; b < 4; b++) begin
         checked_access(adr, 32'h8c4f_a219 + 32'(b) * 32'h1111_1111, 4'b0001 << b, 1'b1,
                        $sformatf("byte lane %0d write", b));
         checked_access(adr, '0, 4'hf, 1'b0, $sformatf("byte lane %0d read", b));
      end
      checked_access(adr, 32'hfeed_c0de, 4'b0110, 1'b1, "two byte write");
      checked_access(adr, '0, 4'hf, 1'b0, "two byte read");
   endtask

   task automatic miss_response();
      checked_access(32'h0000_0440, 32'hbad0_0001, 4'hf, 1'b1, "miss write 0x440");
      checked_access(32'hffff_ff40, 32'hbad0_0002, 4'hf, 1'b1, "miss write 0xffffff40");
      checked_access(32'hffff_ff00, '0, 4'hf, 1'b0, "miss read 0xffffff00");
      for (int r = 0; r < num_slaves; r++) begin
         checked_access(32'(r) * 32'h100 + 32'h40, '0, 4'hf, 1'b0,
                        $sformatf("after miss region %0d", r));
      end
   endtask

   task automatic random_traffic();
      logic [31:0]               v;
      logic [31:0]               adr;
      logic [2:0]                hi;
      logic [23:0]               region;
      logic [5:0]                word;
      logic                      we;
      logic [3:0]                sel;
      wb_intercon_pkg::wb_data_t dat;
      // known contents everywhere first.
      for (int i = 0; i < num_slaves * mem_words; i++) begin
         adr = 32'(i) * 32'd4;
         checked_access(adr, fill_word(adr), 4'hf, 1'b1, "fill");
      end
      for (int n = 0; n < 200; n++) begin
         v = rand_bits(3);
         hi = v[2:0];
         region = {21'd0, hi};
         // upper half of hi is unmapped, spread over the whole field.
         if (hi[2]) begin
            v = rand_bits(21);
            region = {v[20:0], hi};
         end
         v = rand_bits(6);
         word = v[5:0];
         v = rand_bits(1);
         we = v[0];
         v = rand_bits(4);
         sel = v[3:0];
         dat = rand_bits(32);
         adr = {region, word, 2'b00};
         checked_access(adr, dat, sel, we, $sformatf("random access %0d", n));
      end
   endtask

   initial begin
      rst_n   = 1'b0;
      wbm_adr = '0;
      wbm_dat = '0;
      wbm_sel = '0;
      wbm_we  = 1'b0;
      wbm_cyc = 1'b0;
      wbm_stb = 1'b0;
      reset_state();
      region_routing();
      byte_lanes();
      miss_response();
      random_traffic();
      $display("errors: data %0d, response %0d, stall %0d", data_errs, resp_errs, stall_errs);
      if (data_errs + resp_errs + stall_errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* wb_intercon_top.f */
wb_intercon_pkg.sv
wb_if.sv
wb_ram.sv
wb_mux.sv
wb_intercon_top.sv
wb_intercon_chk.sv
wb_intercon_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module wb_intercon_tb \
   -f wb_intercon_top.f || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/Vwb_intercon_tb)
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1
